// File: hw/midi_cfg.svh
// Build-time constants for the MIDI input receiver
// Included by the RTL and the testbench wherever bit timing,
// the drop counter width or the register reset values are needed

`ifndef MIDI_CFG_SVH
`define MIDI_CFG_SVH

// Serial bit timing in clock cycles, one 10-bit frame is ten of these
`define MIDI_CLKS_PER_BIT 32

// Width of the bit-time counter in the UART receiver
`define MIDI_BIT_CNT_W $clog2(`MIDI_CLKS_PER_BIT)

// Saturating drop counter width
`define MIDI_DROP_CNT_W 8

// Configuration after reset, all channels and system messages accepted
`define MIDI_MASK_RESET 16'hffff
`define MIDI_SYS_EN_RESET 1'b1

`endif

// File: hw/midi_pkg.sv
// Shared types of the MIDI input receiver
// Holds the parsed command encoding, the message record passed from the
// decoder to the filter and the configuration record of the register block

package midi_pkg;

    // ----------------------------------------
    // Parsed command
    // ----------------------------------------
    // System commands start at cmd_sys_time_qf, the filter relies on
    // this ordering to tell channel and system messages apart
    typedef enum logic [4:0] {
        cmd_none           = 5'd0,
        cmd_note_off       = 5'd1,
        cmd_note_on        = 5'd2,
        cmd_aftertouch     = 5'd3,
        cmd_ctrl_change    = 5'd4,
        cmd_prog_change    = 5'd5,
        cmd_ch_pressure    = 5'd6,
        cmd_pitch_bend     = 5'd7,
        cmd_sys_time_qf    = 5'd8,
        cmd_sys_song_pos   = 5'd9,
        cmd_sys_song_sel   = 5'd10,
        cmd_sys_timing_clk = 5'd11,
        cmd_sys_start      = 5'd12,
        cmd_sys_cont       = 5'd13,
        cmd_sys_stop       = 5'd14,
        cmd_sys_reset      = 5'd15
    } midi_cmd_e;

    // ----------------------------------------
    // Parsed message, 23 bits
    // ----------------------------------------
    typedef struct packed {
        midi_cmd_e  cmd;
        logic [3:0] chan_sys;   // channel or system subcode
        logic [6:0] data0;      // zero when not carried
        logic [6:0] data1;      // zero when not carried
    } midi_msg_t;

    // ----------------------------------------
    // Filter configuration, 17 bits
    // ----------------------------------------
    typedef struct packed {
        logic [15:0] chan_mask;  // set bit accepts that channel
        logic        sys_enable;
    } midi_cfg_t;

endpackage

// File: hw/midi_uart_rx.sv
// 8N1 serial byte receiver for the MIDI input line
// Synchronizes the line, confirms the start bit at its middle and samples
// the data bits LSB first; byte_valid or framing_err pulses for one cycle
// after the middle sample of the stop bit

`include "midi_cfg.svh"

module midi_uart_rx (
    input  logic       reset,
    input  logic       clk,
    input  logic       midi_in,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       framing_err
);

    localparam int cnt_w = `MIDI_BIT_CNT_W;
    localparam logic [cnt_w-1:0] cnt_half = cnt_w'(`MIDI_CLKS_PER_BIT / 2 - 1);
    localparam logic [cnt_w-1:0] cnt_full = cnt_w'(`MIDI_CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_e;

    logic [1:0]       sync_q;
    logic             rx;
    state_e           state;
    logic [cnt_w-1:0] bit_timer;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    // Two-stage synchronizer, starts at the idle level
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], midi_in};
        end
    end

    assign rx = sync_q[1];

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state       <= st_idle;
            bit_timer   <= '0;
            bit_idx     <= '0;
            byte_valid  <= 1'b0;
            framing_err <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            framing_err <= 1'b0;
            case (state)
                st_idle: begin
                    bit_timer <= '0;
                    bit_idx   <= '0;
                    if (!rx) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (bit_timer == cnt_half) begin
                        bit_timer <= '0;
                        // Glitch gone by mid start bit, back to idle
                        state     <= rx ? st_idle : st_data;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_timer == cnt_full) begin
                        bit_timer <= '0;
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_timer == cnt_full) begin
                        bit_timer   <= '0;
                        state       <= st_idle;
                        byte_valid  <= rx;
                        framing_err <= !rx;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data shifts in from the top, LSB arrives first
    always_ff @(posedge reset) begin
        if (state == st_data && bit_timer == cnt_full) begin
            shift_q <= {rx, shift_q[7:1]};
        end
    end

    assign byte_data = shift_q;

endmodule

// File: hw/midi_decoder.sv
// MIDI status and data byte parser
// Takes received bytes and assembles complete messages; midi_rdy pulses
// for one cycle after the last byte of a message, with midi_msg stable
// until the next status byte arrives

module midi_decoder (
    input  logic                reset,
    input  logic                clk,
    input  logic                byte_valid,
    input  logic [7:0]          byte_data,
    output logic                midi_rdy,
    output midi_pkg::midi_msg_t midi_msg
);

    import midi_pkg::*;

    typedef enum logic [2:0] {
        st_wait_cmd,
        st_wait_dts,
        st_wait_dt0,
        st_wait_dt1,
        st_send_msg
    } state_e;

    state_e    state;
    state_e    next_state;
    midi_cmd_e dec_cmd;
    logic [1:0] dec_npar;
    logic      is_status;

    assign is_status = byte_data[7];

    // ----------------------------------------
    // Status byte classification
    // ----------------------------------------
    // cmd_none marks a skipped status code
    always_comb begin
        dec_cmd  = cmd_none;
        dec_npar = 2'd0;
        case (byte_data[6:4])
            3'h0: begin
                dec_cmd  = cmd_note_off;
                dec_npar = 2'd2;
            end
            3'h1: begin
                dec_cmd  = cmd_note_on;
                dec_npar = 2'd2;
            end
            3'h2: begin
                dec_cmd  = cmd_aftertouch;
                dec_npar = 2'd2;
            end
            3'h3: begin
                dec_cmd  = cmd_ctrl_change;
                dec_npar = 2'd2;
            end
            3'h4: begin
                dec_cmd  = cmd_prog_change;
                dec_npar = 2'd1;
            end
            3'h5: begin
                dec_cmd  = cmd_ch_pressure;
                dec_npar = 2'd1;
            end
            3'h6: begin
                dec_cmd  = cmd_pitch_bend;
                dec_npar = 2'd2;
            end
            default: begin
                case (byte_data[3:0])
                    4'h1: begin
                        dec_cmd  = cmd_sys_time_qf;
                        dec_npar = 2'd1;
                    end
                    4'h2: begin
                        dec_cmd  = cmd_sys_song_pos;
                        dec_npar = 2'd2;
                    end
                    4'h3: begin
                        dec_cmd  = cmd_sys_song_sel;
                        dec_npar = 2'd1;
                    end
                    // Real-time messages carry no data
                    4'h8: dec_cmd = cmd_sys_timing_clk;
                    4'ha: dec_cmd = cmd_sys_start;
                    4'hb: dec_cmd = cmd_sys_cont;
                    4'hc: dec_cmd = cmd_sys_stop;
                    4'hf: dec_cmd = cmd_sys_reset;
                    default: dec_cmd = cmd_none;
                endcase
            end
        endcase
    end

    // ----------------------------------------
    // Parser FSM
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            st_wait_cmd: begin
                if (byte_valid && is_status && dec_cmd != cmd_none) begin
                    next_state = (dec_npar == 2'd0) ? st_send_msg :
                                 (dec_npar == 2'd1) ? st_wait_dts : st_wait_dt0;
                end
            end
            // A status byte mid-message aborts it
            st_wait_dts: begin
                if (byte_valid) begin
                    next_state = is_status ? st_wait_cmd : st_send_msg;
                end
            end
            st_wait_dt0: begin
                if (byte_valid) begin
                    next_state = is_status ? st_wait_cmd : st_wait_dt1;
                end
            end
            st_wait_dt1: begin
                if (byte_valid) begin
                    next_state = is_status ? st_wait_cmd : st_send_msg;
                end
            end
            default: next_state = st_wait_cmd;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= st_wait_cmd;
        end else begin
            state <= next_state;
        end
    end

    assign midi_rdy = (state == st_send_msg);

    // Message fields load on the byte strobe
    always_ff @(posedge reset) begin
        if (byte_valid) begin
            if (state == st_wait_cmd && is_status && dec_cmd != cmd_none) begin
                midi_msg.cmd      <= dec_cmd;
                midi_msg.chan_sys <= byte_data[3:0];
                midi_msg.data0    <= '0;
                midi_msg.data1    <= '0;
            end else if (!is_status) begin
                if (state == st_wait_dts || state == st_wait_dt0) begin
                    midi_msg.data0 <= byte_data[6:0];
                end else if (state == st_wait_dt1) begin
                    midi_msg.data1 <= byte_data[6:0];
                end
            end
        end
    end

endmodule

// File: hw/midi_filter_regs.sv
// Configuration registers for the MIDI message filter
// Address 0 holds the 16-bit channel mask, address 1 the system enable
// in bit 0 of the write data; writes take effect the next cycle

`include "midi_cfg.svh"

module midi_filter_regs (
    input  logic                reset,
    input  logic                clk,
    input  logic                cfg_wr,
    input  logic                cfg_addr,
    input  logic [15:0]         cfg_wdata,
    output midi_pkg::midi_cfg_t cfg
);

    localparam logic addr_chan_mask = 1'b0;
    localparam logic addr_sys_en    = 1'b1;

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cfg.chan_mask  <= `MIDI_MASK_RESET;
            cfg.sys_enable <= `MIDI_SYS_EN_RESET;
        end else if (cfg_wr) begin
            case (cfg_addr)
                addr_chan_mask: cfg.chan_mask <= cfg_wdata;
                addr_sys_en:    cfg.sys_enable <= cfg_wdata[0];
            endcase
        end
    end

endmodule

// File: hw/midi_msg_filter.sv
// Channel and system message gate
// Passes decoded messages whose channel bit or system enable is set in
// the configuration and counts the rejected ones in a saturating counter;
// msg_valid and drop_count follow midi_rdy by one cycle

`include "midi_cfg.svh"

module midi_msg_filter (
    input  logic                        reset,
    input  logic                        clk,
    input  logic                        midi_rdy,
    input  midi_pkg::midi_msg_t         midi_msg,
    input  midi_pkg::midi_cfg_t         cfg,
    output logic                        msg_valid,
    output midi_pkg::midi_msg_t         msg,
    output logic [`MIDI_DROP_CNT_W-1:0] drop_count
);

    import midi_pkg::*;

    logic is_sys;
    logic accept;

    // Quarter frame and everything after it is a system message
    assign is_sys = (midi_msg.cmd >= cmd_sys_time_qf);
    assign accept = is_sys ? cfg.sys_enable : cfg.chan_mask[midi_msg.chan_sys];

    // ----------------------------------------
    // Strobe and drop counter
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            msg_valid  <= 1'b0;
            drop_count <= '0;
        end else begin
            msg_valid <= midi_rdy && accept;
            // Saturates at all ones
            if (midi_rdy && !accept && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (midi_rdy && accept) begin
            msg <= midi_msg;
        end
    end

endmodule

// File: hw/midi_rx_top.sv
// MIDI input receiver top level
// Serial line in, filtered one-cycle message strobes out; the channel mask
// and system enable are written through the cfg_* port

`include "midi_cfg.svh"

module midi_rx_top (
    input  logic                        reset,
    input  logic                        clk,
    input  logic                        midi_in,
    input  logic                        cfg_wr,
    input  logic                        cfg_addr,
    input  logic [15:0]                 cfg_wdata,
    output logic                        msg_valid,
    output midi_pkg::midi_msg_t         msg,
    output logic                        framing_err,
    output logic [`MIDI_DROP_CNT_W-1:0] drop_count
);

    import midi_pkg::*;

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       midi_rdy;
    midi_msg_t  dec_msg;
    midi_cfg_t  cfg;

    midi_uart_rx u_uart_rx (
        .reset       (reset),
        .clk         (clk),
        .midi_in     (midi_in),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .framing_err (framing_err)
    );

    midi_decoder u_decoder (
        .reset      (reset),
        .clk        (clk),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .midi_rdy   (midi_rdy),
        .midi_msg   (dec_msg)
    );

    midi_filter_regs u_filter_regs (
        .reset     (reset),
        .clk       (clk),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    midi_msg_filter u_msg_filter (
        .reset      (reset),
        .clk        (clk),
        .midi_rdy   (midi_rdy),
        .midi_msg   (dec_msg),
        .cfg        (cfg),
        .msg_valid  (msg_valid),
        .msg        (msg),
        .drop_count (drop_count)
    );

endmodule

// File: sim/midi_rx_properties.sv
// Concurrent assertions on the MIDI receiver top level
// Bound into every midi_rx_top instance by the bind statement at the end
// The clock port is reset, the asynchronous reset port is clk

module midi_rx_properties (
    input logic                reset,
    input logic                clk,
    input logic                msg_valid,
    input midi_pkg::midi_msg_t msg,
    input logic                framing_err
);

    timeunit 1ns;
    timeprecision 100ps;

    import midi_pkg::*;

    // Message strobe lasts one cycle
    msg_single_cycle: assert property (
        @(posedge reset) disable iff (clk) msg_valid |=> !msg_valid
    ) else $error("msg_valid high two cycles in a row");

    // Strobes stay low while reset is applied
    quiet_in_reset: assert property (
        @(posedge reset) clk |-> (!msg_valid && !framing_err)
    ) else $error("strobe high while reset is applied");

    // Real-time commands carry no data
    no_data_zero_param: assert property (
        @(posedge reset) disable iff (clk)
            (msg_valid && msg.cmd >= cmd_sys_timing_clk) |-> (msg.data0 == '0 && msg.data1 == '0)
    ) else $error("data field set on a zero-parameter message");

endmodule

bind midi_rx_top midi_rx_properties u_properties (
    .reset       (reset),
    .clk         (clk),
    .msg_valid   (msg_valid),
    .msg         (msg),
    .framing_err (framing_err)
);

// File: sim/midi_rx_tb.sv
// Self-checking testbench for the MIDI input receiver
// Sends a random serial byte stream with aborts, stray bytes, bad frames
// and register writes, and checks each filtered message and the drop
// count against a reference model of the parser and the filter

`include "midi_cfg.svh"

module midi_rx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import midi_pkg::*;

    localparam int n_frames   = 2000;
    localparam int frame_slot = 10 * `MIDI_CLKS_PER_BIT + 4;
    // The stream may run past n_frames by one message and its noise frames
    localparam int cycle_limit = (n_frames + 16) * frame_slot + 1000;

    typedef struct packed {
        midi_msg_t                   msg;
        logic [`MIDI_DROP_CNT_W-1:0] drop;
    } expect_t;

    logic                        reset;    // DUT clock
    logic                        clk;      // DUT async reset, active high
    logic                        midi_in;
    logic                        cfg_wr;
    logic                        cfg_addr;
    logic [15:0]                 cfg_wdata;
    logic                        msg_valid;
    midi_msg_t                   msg;
    logic                        framing_err;
    logic [`MIDI_DROP_CNT_W-1:0] drop_count;

    logic [31:0]                 lcg_state = 32'd58861;
    expect_t                     exp_q[$];
    midi_cfg_t                   model_cfg;
    midi_msg_t                   model_msg;
    logic [`MIDI_DROP_CNT_W-1:0] model_drop = '0;
    logic                        model_busy = 1'b0;
    int                          model_need = 0;
    int                          model_got = 0;
    int                          frames_sent = 0;
    int                          bad_sent = 0;
    int                          bad_seen = 0;
    int                          cycle_count = 0;

    midi_rx_top i_dut (
        .reset       (reset),
        .clk         (clk),
        .midi_in     (midi_in),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .msg_valid   (msg_valid),
        .msg         (msg),
        .framing_err (framing_err),
        .drop_count  (drop_count)
    );

    initial begin
        reset = 1'b0;
        forever #2 reset = ~reset;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic midi_cmd_e status_cmd(input logic [7:0] st);
        case (st[7:4])
            4'h8: return cmd_note_off;
            4'h9: return cmd_note_on;
            4'ha: return cmd_aftertouch;
            4'hb: return cmd_ctrl_change;
            4'hc: return cmd_prog_change;
            4'hd: return cmd_ch_pressure;
            4'he: return cmd_pitch_bend;
            default: begin
                case (st[3:0])
                    4'h1: return cmd_sys_time_qf;
                    4'h2: return cmd_sys_song_pos;
                    4'h3: return cmd_sys_song_sel;
                    4'h8: return cmd_sys_timing_clk;
                    4'ha: return cmd_sys_start;
                    4'hb: return cmd_sys_cont;
                    4'hc: return cmd_sys_stop;
                    4'hf: return cmd_sys_reset;
                    default: return cmd_none;
                endcase
            end
        endcase
    endfunction

    // Data bytes a status byte takes, -1 for a skipped code
    function automatic int status_params(input logic [7:0] st);
        midi_cmd_e c;
        c = status_cmd(st);
        if (c == cmd_none) begin
            return -1;
        end
        if (c inside {cmd_prog_change, cmd_ch_pressure, cmd_sys_time_qf, cmd_sys_song_sel}) begin
            return 1;
        end
        if (c >= cmd_sys_timing_clk) begin
            return 0;
        end
        return 2;
    endfunction

    task automatic model_finish();
        logic take;
        if (model_msg.cmd >= cmd_sys_time_qf) begin
            take = model_cfg.sys_enable;
        end else begin
            take = model_cfg.chan_mask[model_msg.chan_sys];
        end
        if (take) begin
            exp_q.push_back('{msg: model_msg, drop: model_drop});
        end else if (model_drop != '1) begin
            model_drop = model_drop + 1'b1;
        end
    endtask

    task automatic model_byte(input logic [7:0] b);
        int n;
        if (b[7] && model_busy) begin
            // Abort, the status byte itself is dropped too
            model_busy = 1'b0;
        end else if (b[7]) begin
            n = status_params(b);
            if (n >= 0) begin
                model_msg  = '{cmd: status_cmd(b), chan_sys: b[3:0], data0: 7'd0, data1: 7'd0};
                model_need = n;
                model_got  = 0;
                if (n == 0) begin
                    model_finish();
                end else begin
                    model_busy = 1'b1;
                end
            end
        end else if (model_busy) begin
            if (model_got == 0) begin
                model_msg.data0 = b[6:0];
            end else begin
                model_msg.data1 = b[6:0];
            end
            model_got++;
            if (model_got == model_need) begin
                model_busy = 1'b0;
                model_finish();
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic send_frame(input logic [7:0] b, input logic bad);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            if (i == 9 && bad) begin
                // Low across the stop bit middle, high again before the
                // receiver would confirm a new start bit
                midi_in = 1'b0;
                repeat (`MIDI_CLKS_PER_BIT * 3 / 4) @(negedge reset);
                midi_in = 1'b1;
                repeat (`MIDI_CLKS_PER_BIT / 4) @(negedge reset);
            end else begin
                midi_in = bits[i];
                repeat (`MIDI_CLKS_PER_BIT) @(negedge reset);
            end
        end
        midi_in = 1'b1;
        repeat (4) @(negedge reset);
        frames_sent++;
        if (bad) begin
            bad_sent++;
        end
    endtask

    // Occasionally a bad frame goes out first, the model never sees it
    task automatic push_byte(input logic [7:0] b);
        logic [15:0] r;
        r = lcg_next();
        if (r % 20 == 0) begin
            send_frame(r[15:8], 1'b1);
        end
        model_byte(b);
        send_frame(b, 1'b0);
    endtask

    task automatic write_cfg(input logic addr, input logic [15:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge reset);
        cfg_wr = 1'b0;
        if (addr) begin
            model_cfg.sys_enable = data[0];
        end else begin
            model_cfg.chan_mask = data;
        end
    endtask

    task automatic run_stream();
        logic [15:0] r;
        logic [7:0]  st;
        int          n;
        while (frames_sent < n_frames) begin
            r = lcg_next();
            if (r % 12 == 0) begin
                push_byte({1'b0, r[14:8]});
            end else begin
                st = {1'b1, r[14:8]};
                push_byte(st);
                n = status_params(st);
                for (int i = 0; i < n; i++) begin
                    r = lcg_next();
                    if (r % 16 == 0) begin
                        push_byte({1'b1, r[14:8]});
                        break;
                    end
                    push_byte({1'b0, r[14:8]});
                end
            end
            r = lcg_next();
            if (r % 6 == 0) begin
                write_cfg(r[8], lcg_next());
            end
        end
    endtask

    // ----------------------------------------
    // Checking
    // ----------------------------------------
    task automatic end_failed();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        end_failed();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, want);
            end_failed();
        end
    endtask

    task automatic check_message();
        expect_t e;
        if (exp_q.size() == 0) begin
            abort_run("message received while none was expected");
        end else begin
            e = exp_q.pop_front();
            check_value("msg", msg, e.msg);
            check_value("drop_count", drop_count, e.drop);
        end
    endtask

    // Outputs only change on the rising edge
    always @(negedge reset) begin
        cycle_count++;
        if (framing_err) begin
            bad_seen++;
        end
        if (msg_valid) begin
            check_message();
        end
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout, expected messages not received");
        end
    end

    initial begin
        clk       = 1'b0;
        midi_in   = 1'b1;
        cfg_wr    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = 16'h0000;
        model_cfg = '{chan_mask: `MIDI_MASK_RESET, sys_enable: `MIDI_SYS_EN_RESET};
        #1 clk = 1'b1;
        repeat (2) @(negedge reset);
        clk = 1'b0;
        repeat (4) @(negedge reset);
        run_stream();
        while (exp_q.size() != 0) begin
            @(negedge reset);
        end
        // Room for any stray strobe
        repeat (2 * frame_slot) @(negedge reset);
        check_value("drop_count", drop_count, model_drop);
        check_value("framing_err pulses", bad_seen, bad_sent);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/midi_pkg.sv
hw/midi_uart_rx.sv
hw/midi_decoder.sv
hw/midi_filter_regs.sv
hw/midi_msg_filter.sv
hw/midi_rx_top.sv
sim/midi_rx_properties.sv
sim/midi_rx_tb.sv
